/* tb.f */
common/soc_pkg.sv
rtl/page_decoder.sv
rtl/word_ram.sv
io/matrix_shifter.sv
io/spi_flash_reader.sv
io/io_regs.sv
rtl/soc_top.sv
test/tb_spi_flash_model.sv
test/tb_soc.sv

/* test/tb_soc.sv */
/*
  testbench for soc_top with Wishbone master tasks, RAM lane merge,
  leds and buttons, matrix output and back-pressure and a flash read
*/
`timescale 1ns/1ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

  localparam int MTX_DIV    = 8;
  localparam int MAX_CYCLES = 20000;  // far above the length of the tests

  logic        clk;
  logic        RESET;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [3:0]  leds;
  logic [5:0]  buttons;
  logic        mtx_din, mtx_cs, mtx_clk;
  logic        spi_mosi, spi_cs_n, spi_clk, spi_miso;
  logic [31:0] flash_rx;  // bits seen by the flash model

  int          errors = 0;
  int          cycle_cnt = 0;
  int          seed = 74819;
  logic [15:0] mtx_bits;   // sampled on mtx_clk rising edges
  int          mtx_pulses;
  int          cs_low_cycles;
  logic        cs_rose;    // mtx_cs went high since last clear

  soc_top #(.RAM_WORDS(1024), .MTX_DIV(MTX_DIV)) soc_top_inst (
    .clk (clk), .RESET (RESET), .wb_req (wb_req), .wb_rsp (wb_rsp),
    .leds (leds), .buttons (buttons),
    .mtx_din (mtx_din), .mtx_cs (mtx_cs), .mtx_clk (mtx_clk),
    .spi_mosi (spi_mosi), .spi_cs_n (spi_cs_n), .spi_clk (spi_clk),
    .spi_miso (spi_miso)
  );

  tb_spi_flash_model flash_inst (
    .spi_clk (spi_clk), .spi_cs_n (spi_cs_n), .spi_mosi (spi_mosi),
    .spi_miso (spi_miso), .rx_word (flash_rx)
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, a transfer never finished", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // matrix monitors
  always @(posedge mtx_clk) begin
    mtx_bits = {mtx_bits[14:0], mtx_din};
    mtx_pulses++;
  end
  always @(posedge clk) if (!mtx_cs) cs_low_cycles++;
  always @(posedge mtx_cs) cs_rose = 1'b1;

  a_ack_pulse : assert property (@(posedge clk) disable iff (!RESET)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      errors++;
      $display("ack stayed high for more than one cycle");
    end
  a_mtx_frame : assert property (@(posedge clk) mtx_clk |-> !mtx_cs)
    else begin
      errors++;
      $display("mtx_clk pulsed while mtx_cs was high");
    end
  a_spi_idle : assert property (@(posedge clk) spi_cs_n |-> !spi_clk)
    else begin
      errors++;
      $display("spi_clk high outside a flash frame");
    end
  // sampled mid-cycle so the reset values have settled
  a_reset_state : assert property (@(negedge clk) !RESET |->
    (!wb_rsp.ack && leds == 4'h0 && mtx_cs && spi_cs_n && !mtx_clk && !spi_clk))
    else begin
      errors++;
      $display("outputs not in their idle state during reset");
    end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_idle();
    check_val("wb_rsp.ack", 0, wb_rsp.ack);
    check_val("leds", 0, leds);
    check_val("mtx_cs", 1, mtx_cs);
    check_val("spi_cs_n", 1, spi_cs_n);
    check_val("mtx_clk", 0, mtx_clk);
    check_val("spi_clk", 0, spi_clk);
  endtask

  function automatic logic [23:0] ram_addr(input int idx);
    return 24'(idx * 4);  // word index to byte address
  endfunction

  function automatic logic [23:0] io_addr(input int r);
    return 24'(1 << IO_PAGE_BIT) | 24'(1 << (r + 2));  // one-hot word bit
  endfunction

  // classic cycle with stb held until ack and dropped on the ack cycle
  task automatic wb_write(input logic [23:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: sel, adr: adr, dat: dat};
    do @(negedge clk); while (wb_rsp.ack !== 1'b1);
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [23:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 4'hF, adr: adr, dat: 32'h0};
    do @(negedge clk); while (wb_rsp.ack !== 1'b1);
    dat = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic clear_matrix_monitor();
    mtx_bits = 16'h0;
    mtx_pulses = 0;
    cs_low_cycles = 0;
  endtask

  task automatic check_matrix(input logic [15:0] word);
    while (mtx_cs !== 1'b1) @(negedge clk);  // end of transfer
    check_val("mtx_din bits", word, mtx_bits);
    check_val("mtx_clk pulses", 16, mtx_pulses);
    check_val("mtx_cs low cycles", 16 * MTX_DIV, cs_low_cycles);
  endtask

  initial begin
    logic [31:0] shadow [8];  // expected ram contents
    logic [31:0] d, r;
    logic [3:0]  m;
    logic [15:0] w1, w2;
    logic [23:0] fa;
    clk = 1'b0;
    RESET = 1'b0;
    wb_req = '0;
    buttons = 6'h0;
    clear_matrix_monitor();
    cs_rose = 1'b0;
    @(negedge clk);
    check_idle();  // during reset
    @(negedge clk);
    RESET = 1'b1;
    @(negedge clk);
    check_idle();  // just after

    // ram full words then partial lanes on top
    for (int i = 0; i < 8; i++) begin
      d = $random(seed);
      wb_write(ram_addr(i), 4'hF, d);
      shadow[i] = d;
    end
    for (int i = 0; i < 8; i++) begin
      d = $random(seed);
      m = 4'($random(seed));
      wb_write(ram_addr(i), m, d);
      for (int l = 0; l < 4; l++) if (m[l]) shadow[i][8*l +: 8] = d[8*l +: 8];
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(ram_addr(i), r);
      check_val($sformatf("ram word %0d", i), shadow[i], r);
    end

    // leds share word index 1 with ram word 1
    d = $random(seed);
    wb_write(io_addr(IO_LEDS), 4'hF, d);
    check_val("leds", d[3:0], leds);
    wb_read(io_addr(IO_LEDS), r);
    check_val("led register", {28'h0, d[3:0]}, r);
    wb_read(ram_addr(1), r);
    check_val("ram word 1 after io write", shadow[1], r);
    @(negedge clk);
    buttons = 6'($random(seed));
    wb_read(io_addr(IO_BUTTONS), r);
    check_val("buttons register", {26'h0, buttons}, r);

    // one matrix word
    w1 = 16'($random(seed));
    clear_matrix_monitor();
    wb_write(io_addr(IO_MTX_DATA), 4'hF, {16'hDEAD, w1});
    check_matrix(w1);

    // back-pressure on a second word
    w1 = 16'($random(seed));
    w2 = 16'($random(seed));
    wb_write(io_addr(IO_MTX_DATA), 4'hF, {16'h0, w1});
    wb_read(io_addr(IO_MTX_STAT), r);
    check_val("matrix status while sending", 1, r);
    cs_rose = 1'b0;
    wb_write(io_addr(IO_MTX_DATA), 4'hF, {16'h0, w2});
    assert (cs_rose) else begin
      errors++;
      $display("second matrix write acknowledged before the first transfer ended");
    end
    clear_matrix_monitor();  // second transfer has not pulsed yet
    check_matrix(w2);
    wb_read(io_addr(IO_MTX_STAT), r);
    check_val("matrix status when idle", 0, r);

    // flash byte read
    fa = 24'($random(seed));
    wb_write(io_addr(IO_FLASH), 4'hF, {8'h0, fa});
    wb_read(io_addr(IO_FLASH), r);  // stalls until the reader is idle
    check_val("flash register", {23'h0, 1'b0, fa[7:0] ^ 8'hA5}, r);
    check_val("flash command and address", {8'h03, fa}, flash_rx);
    check_val("spi_cs_n", 1, spi_cs_n);

    repeat (4) @(negedge clk);
    $display("errors: %0d, cycles: %0d", errors, cycle_cnt);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_spi_flash_model.sv */
/*
  behavioral SPI flash: shifts in command and address on rising sclk,
  answers with one byte (address low byte xor 0xA5), MSB first
*/
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash_model (
  input  wire logic   spi_clk,
  input  wire logic   spi_cs_n,
  input  wire logic   spi_mosi,
  output logic        spi_miso,
  output logic [31:0] rx_word    // last 32 bits received, command first
);

  int         bit_cnt;  // sclk rising edges in this frame
  logic [7:0] out_sh;   // reply byte, msb goes out first

  initial begin
    bit_cnt  = 0;
    rx_word  = 32'h0;
    out_sh   = 8'h0;
    spi_miso = 1'b0;
  end

  // new frame
  always @(negedge spi_cs_n) bit_cnt = 0;

  always @(posedge spi_clk) begin
    if (!spi_cs_n && bit_cnt < 32) begin
      rx_word = {rx_word[30:0], spi_mosi};
      // address complete, reply depends only on its low byte
      if (bit_cnt == 31) out_sh = rx_word[7:0] ^ 8'hA5;
    end
    bit_cnt++;
  end

  // reply bits change while sclk is low
  always @(negedge spi_clk) begin
    if (bit_cnt >= 32) begin
      spi_miso <= out_sh[7];
      out_sh = {out_sh[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* rtl/soc_top.sv */
/*
  soc top: Wishbone classic slave port split into a word RAM page
  and a one-hot IO page (leds, buttons, led matrix, spi flash)
*/
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter int RAM_WORDS = 1024,  // ram depth in 32-bit words
  parameter int MTX_DIV   = 8      // system clocks per matrix bit
) (
  input  wire logic    clk,
  input  wire logic    RESET,     // async, active low
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp,
  output logic [3:0]   leds,
  input  wire logic [5:0] buttons,
  output logic         mtx_din,
  output logic         mtx_cs,
  output logic         mtx_clk,
  output logic         spi_mosi,
  output logic         spi_cs_n,
  output logic         spi_clk,
  input  wire logic    spi_miso
);

  wb_req_t ram_req, io_req;  // per-page requests, strobe gated
  wb_rsp_t ram_rsp, io_rsp;

  page_decoder page_decoder_inst (
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp),
    .io_req  (io_req),
    .io_rsp  (io_rsp)
  );

  word_ram #(.RAM_WORDS(RAM_WORDS)) word_ram_inst (
    .clk   (clk),
    .RESET (RESET),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  io_regs #(.MTX_DIV(MTX_DIV)) io_regs_inst (
    .clk      (clk),
    .RESET    (RESET),
    .req      (io_req),
    .rsp      (io_rsp),
    .leds     (leds),
    .buttons  (buttons),
    .mtx_din  (mtx_din),
    .mtx_cs   (mtx_cs),
    .mtx_clk  (mtx_clk),
    .spi_mosi (spi_mosi),
    .spi_cs_n (spi_cs_n),
    .spi_clk  (spi_clk),
    .spi_miso (spi_miso)
  );

endmodule

`default_nettype wire

/* io/io_regs.sv */
/*
  IO page: one-hot register decode, led register, OR-combined read word,
  start pulses to the matrix and flash engines, ack held while busy
*/
`timescale 1ns/1ps
`default_nettype none

module io_regs import soc_pkg::*; #(
  parameter int MTX_DIV = 8
) (
  input  wire logic       clk,
  input  wire logic       RESET,
  input  wb_req_t         req,
  output wb_rsp_t         rsp,
  output logic [3:0]      leds,
  input  wire logic [5:0] buttons,
  output logic            mtx_din,
  output logic            mtx_cs,
  output logic            mtx_clk,
  output logic            spi_mosi,
  output logic            spi_cs_n,
  output logic            spi_clk,
  input  wire logic       spi_miso
);

  logic [10:0]       rbit;      // one bit per register
  logic              sel;
  logic              wait_eng;  // selected engine still busy
  logic              take;      // transfer accepted this cycle
  logic              wr_take;
  logic              mtx_start, mtx_busy;
  logic              fl_start, fl_busy;
  logic [7:0]        fl_data;
  logic [DATA_W-1:0] rword;     // combined read word
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  assign rbit = req.adr[12:2];
  assign sel  = req.cyc & req.stb;

  // back-pressure: matrix only on data writes, flash on any access
  assign wait_eng = (rbit[IO_MTX_DATA] & req.we & mtx_busy)
                  | (rbit[IO_FLASH] & fl_busy);

  assign take      = sel & ~ack_q & ~wait_eng;
  assign wr_take   = take & req.we;
  assign mtx_start = wr_take & rbit[IO_MTX_DATA];
  assign fl_start  = wr_take & rbit[IO_FLASH];

  // read mux, unmapped bits give 0
  always_comb begin
    rword = '0;
    if (rbit[IO_LEDS])     rword = rword | {28'b0, leds};
    if (rbit[IO_MTX_STAT]) rword = rword | {31'b0, mtx_busy};
    if (rbit[IO_FLASH])    rword = rword | {23'b0, fl_busy, fl_data};
    if (rbit[IO_BUTTONS])  rword = rword | {26'b0, buttons};
  end

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      ack_q <= 1'b0;
      leds  <= 4'b0;
    end else begin
      ack_q <= take;  // single pulse, take needs ~ack_q
      if (wr_take && rbit[IO_LEDS]) leds <= req.dat[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (take) rdata_q <= rword;  // snapshot for the ack cycle
  end

  assign rsp.ack = ack_q;
  assign rsp.dat = rdata_q;

  matrix_shifter #(.DIV(MTX_DIV)) matrix_shifter_inst (
    .clk     (clk),
    .RESET   (RESET),
    .start   (mtx_start),
    .word    (req.dat[15:0]),
    .busy    (mtx_busy),
    .din     (mtx_din),
    .cs      (mtx_cs),
    .clk_out (mtx_clk)
  );

  spi_flash_reader spi_flash_reader_inst (
    .clk   (clk),
    .RESET (RESET),
    .start (fl_start),
    .addr  (req.dat[23:0]),
    .busy  (fl_busy),
    .data  (fl_data),
    .mosi  (spi_mosi),
    .cs_n  (spi_cs_n),
    .sclk  (spi_clk),
    .miso  (spi_miso)
  );

  // a start only ever hits an idle engine, which then reports busy
  a_mtx_start : assert property (@(posedge clk) disable iff (!RESET)
    mtx_start |-> !mtx_busy ##1 mtx_busy)
    else $error("matrix start issued while busy or engine did not go busy");

  a_fl_start : assert property (@(posedge clk) disable iff (!RESET)
    fl_start |-> !fl_busy ##1 fl_busy)
    else $error("flash start issued while busy or reader did not go busy");

endmodule

`default_nettype wire

/* io/spi_flash_reader.sv */
/*
  spi flash reader that sends read command 0x03 and a 24-bit address
  and then clocks in one byte at one spi bit every two system clocks
*/
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
  input  wire logic        clk,
  input  wire logic        RESET,
  input  wire logic        start,
  input  wire logic [23:0] addr,
  output logic             busy,
  output logic [7:0]       data,
  output logic             mosi,
  output logic             cs_n,
  output logic             sclk,
  input  wire logic        miso
);

  logic        phase;    // high while sclk is high
  logic [31:0] cmd_sh;   // command then address with msb first
  logic [5:0]  snd_cnt;  // bits left to send
  logic [3:0]  rcv_cnt;  // bits left to receive
  logic        sending;
  logic        advance;  // end of the high half of a bit

  assign sending = (snd_cnt != 6'd0);
  assign busy    = sending | (rcv_cnt != 4'd0);
  assign advance = busy & phase;
  assign sclk    = phase;       // toggles only while busy and ends low
  assign mosi    = cmd_sh[31];  // shifts on the falling edge of sclk

  // phase, counters and chip select
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      phase   <= 1'b0;
      snd_cnt <= 6'd0;
      rcv_cnt <= 4'd0;
      cs_n    <= 1'b1;
    end else if (start) begin
      phase   <= 1'b0;
      snd_cnt <= 6'd32;
      cs_n    <= 1'b0;
    end else if (busy) begin
      phase <= ~phase;
      if (phase) begin
        if (sending) begin
          snd_cnt <= snd_cnt - 6'd1;
          if (snd_cnt == 6'd1) rcv_cnt <= 4'd8;  // turn around to receive
        end else begin
          rcv_cnt <= rcv_cnt - 4'd1;
          if (rcv_cnt == 4'd1) cs_n <= 1'b1;  // byte complete
        end
      end
    end
  end

  // command and address shift out on mosi
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET)                  cmd_sh <= 32'h0;
    else if (start)              cmd_sh <= {8'h03, addr};
    else if (advance && sending) cmd_sh <= {cmd_sh[30:0], 1'b0};
  end

  // miso sampled at the end of each high half with msb first
  always_ff @(posedge clk) begin
    if (advance && !sending) data <= {data[6:0], miso};
  end

  a_cs_busy : assert property (@(posedge clk) disable iff (!RESET)
    busy |-> !cs_n)
    else $error("spi flash busy while chip select is deasserted");

endmodule

`default_nettype wire

/* io/matrix_shifter.sv */
/*
  led matrix shifter: 16 bits out MSB first, DIV clocks per bit,
  one-cycle clock pulse at mid-bit, cs low for the whole word
*/
`timescale 1ns/1ps
`default_nettype none

module matrix_shifter #(
  parameter int DIV = 8  // system clocks per bit, at least 2
) (
  input  wire logic        clk,
  input  wire logic        RESET,
  input  wire logic        start,
  input  wire logic [15:0] word,
  output logic             busy,
  output logic             din,
  output logic             cs,       // active low
  output logic             clk_out
);

  localparam int DW = (DIV > 1) ? $clog2(DIV) : 1;

  logic [DW-1:0] div_cnt;  // position inside the current bit
  logic [4:0]    bit_cnt;  // bits left, 0 = idle
  logic [15:0]   shreg;
  logic          bit_end;

  assign busy    = (bit_cnt != 5'd0);
  assign bit_end = (div_cnt == DW'(DIV - 1));
  assign din     = shreg[15];  // msb first

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      div_cnt <= '0;
      bit_cnt <= 5'd0;
      shreg   <= 16'h0;
      cs      <= 1'b1;
      clk_out <= 1'b0;
    end else begin
      // high for the cycle where div_cnt sits at DIV/2
      clk_out <= busy & (div_cnt == DW'(DIV/2 - 1));
      if (start) begin
        shreg   <= word;
        bit_cnt <= 5'd16;
        div_cnt <= '0;
        cs      <= 1'b0;
      end else if (busy) begin
        div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
        if (bit_end) begin
          bit_cnt <= bit_cnt - 5'd1;
          shreg   <= {shreg[14:0], 1'b0};  // next bit onto din
          if (bit_cnt == 5'd1) cs <= 1'b1;  // last bit done
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/word_ram.sv */
/*
  word RAM acting as a Wishbone slave with byte-lane write enables,
  registered read data and a single-cycle acknowledge
*/
`timescale 1ns/1ps
`default_nettype none

module word_ram import soc_pkg::*; #(
  parameter int RAM_WORDS = 1024
) (
  input  wire logic clk,
  input  wire logic RESET,
  input  wb_req_t   req,
  output wb_rsp_t   rsp
);

  localparam int AW = $clog2(RAM_WORDS);  // word address width

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [AW-1:0]     waddr;    // word index without the byte offset
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;
  logic              wr_en;

  assign waddr = req.adr[AW+1:2];
  assign wr_en = req.cyc & req.stb & req.we & ~ack_q;  // once per transfer

  // storage and read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < SEL_W; i++) begin
        if (req.sel[i]) mem[waddr][8*i +: 8] <= req.dat[8*i +: 8];  // lane i
      end
    end
    rdata_q <= mem[waddr];  // old word is valid in the ack cycle
  end

  // ack one cycle after stb and low again while stb is still held
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) ack_q <= 1'b0;
    else        ack_q <= req.cyc & req.stb & ~ack_q;
  end

  assign rsp.ack = ack_q;
  assign rsp.dat = rdata_q;

endmodule

`default_nettype wire

/* rtl/page_decoder.sv */
/*
  page decoder: one address bit picks RAM or IO page, strobe goes
  only to the selected slave and its response goes back
*/
`timescale 1ns/1ps
`default_nettype none

module page_decoder import soc_pkg::*; (
  input  wb_req_t wb_req,   // from the bus master
  output wb_rsp_t wb_rsp,
  output wb_req_t ram_req,  // ram page
  input  wb_rsp_t ram_rsp,
  output wb_req_t io_req,   // io page
  input  wb_rsp_t io_rsp
);

  logic io_sel;  // page bit of the current request

  assign io_sel = wb_req.adr[IO_PAGE_BIT];

  // everything but stb is broadcast to both pages
  always_comb begin
    ram_req     = wb_req;
    io_req      = wb_req;
    ram_req.stb = wb_req.stb & ~io_sel;  // ram sees only its own page
    io_req.stb  = wb_req.stb & io_sel;
  end

  // response follows the page bit, held steady by the master until ack
  always_comb begin
    if (io_sel) begin
      wb_rsp = io_rsp;
    end else begin
      wb_rsp = ram_rsp;
    end
  end

  // both slaves answering at once would mean a strobe leaked into the
  // other page or an ack outlived its transfer
  always_comb begin
    assert final (!(ram_rsp.ack === 1'b1 && io_rsp.ack === 1'b1))
      else $error("ram and io slaves acknowledged in the same cycle");
  end

endmodule

`default_nettype wire

/* common/soc_pkg.sv */
/*
  soc package: Wishbone request/response structs, address map
  constants and the one-hot IO register bit positions
*/
`default_nettype none

package soc_pkg;

  // bus geometry
  localparam int ADDR_W      = 24;  // byte address
  localparam int DATA_W      = 32;
  localparam int SEL_W       = 4;   // one select per byte lane
  localparam int IO_PAGE_BIT = 22;  // high selects the IO page

  // one-hot IO registers, bit index within word address adr[12:2]
  typedef enum int {
    IO_LEDS     = 0,  // rw, 4 lsbs
    IO_MTX_STAT = 1,  // r, bit 0 busy
    IO_MTX_DATA = 2,  // w, low 16 bits shifted out
    IO_FLASH    = 3,  // w starts read at 24-bit addr, r gives {busy, byte}
    IO_BUTTONS  = 4   // r, 6 bits
  } io_reg_e;

  // master -> slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [SEL_W-1:0]  sel;  // byte lane enables
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;  // write data
  } wb_req_t;

  // slave -> master
  typedef struct packed {
    logic              ack;  // single-cycle pulse
    logic [DATA_W-1:0] dat;  // read data, valid with ack
  } wb_rsp_t;

endpackage

`default_nettype wire
